/* sifh.f */
design/sifhGeometryPkg.sv
design/sifhCtrlPkg.sv
design/sifhConfig.sv
design/sifhPeakBinner.sv
design/sifhFsm.sv
design/sifhCountRam.sv
design/sifhTop.sv
testbench/sifhTb.sv

/* testbench/sifhTb.sv */
module sifhTb
    import sifhGeometryPkg::*;
    import sifhCtrlPkg::*;
();

    localparam int numTests = 7;
    localparam int clkHalf = 20;

    // one row of the test table
    typedef struct packed {
        logic        doClear;
        logic        enable;
        shiftT       shift;
        logic [15:0] pairs;
        logic        useRandom;
        logic        repeatPair;
        sampleT      sampA;
        sampleT      sampB;
    } testRowT;

    logic    clk;
    logic    rstN;
    logic    cfgWrite;
    cfgAddrT cfgAddr;
    cfgDataT cfgData;
    logic    sampleValid;
    sampleT  sampleData;
    logic    rdReq;
    ramAddrT rdAddr;
    logic    busy;
    logic    rdValid;
    countT   rdData;

    testRowT     rows [numTests];
    string       names [numTests];
    // reference histogram and frame position
    int          modelCounts [ramDepth];
    int          modelPix;
    int          modelPair;
    logic [31:0] rngState = 32'h3b88_886b;
    int          passCount = 0;
    int          failCount = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    sifhTop i_dut (
        .clk         (clk),
        .rstN        (rstN),
        .cfgWrite    (cfgWrite),
        .cfgAddr     (cfgAddr),
        .cfgData     (cfgData),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .rdReq       (rdReq),
        .rdAddr      (rdAddr),
        .busy        (busy),
        .rdValid     (rdValid),
        .rdData      (rdData)
    );

    initial begin
        clk = 1'b0;
        forever #clkHalf clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // four-state compare, an unknown value never matches
    task automatic checkValue(input string sigName, input int addr,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s addr=%h expected=%h actual=%h", sigName, addr, expected, actual);
            failCount++;
        end else begin
            passCount++;
        end
    endtask

    // histogram rule, max of pair then shift and clip
    function automatic void modelApplyPair(input sampleT a, input sampleT b, input int shift);
        int peak;
        int bin;
        int addr;
        peak = (a > b) ? a : b;
        bin = peak >> shift;
        if (bin > binsPerPixel - 1) begin
            bin = binsPerPixel - 1;
        end
        addr = modelPix * binsPerPixel + bin;
        if (modelCounts[addr] < countMax) begin
            modelCounts[addr]++;
        end
        // pixel steps after dataNum pairs
        modelPair++;
        if (modelPair == dataNum) begin
            modelPair = 0;
            modelPix = (modelPix + 1) % pixelNum;
        end
    endfunction

    function automatic void modelClear();
        foreach (modelCounts[i]) begin
            modelCounts[i] = 0;
        end
        modelPix = 0;
        modelPair = 0;
    endfunction

    // called at a falling edge, returns at the next one
    task automatic writeCfg(input cfgAddrT addr, input cfgDataT data);
        cfgWrite = 1'b1;
        cfgAddr = addr;
        cfgData = data;
        @(negedge clk);
        cfgWrite = 1'b0;
    endtask

    // busy must rise shortly after the clear write and hold 64 cycles
    task automatic measureClear();
        int guard;
        int busyCycles;
        guard = 0;
        busyCycles = 0;
        while (!busy && guard < 8) begin
            @(negedge clk);
            guard++;
        end
        if (!busy) begin
            $display("busy never went high after the clear request");
            failCount++;
        end else begin
            while (busy && busyCycles < 4 * ramDepth) begin
                @(negedge clk);
                busyCycles++;
            end
            checkValue("busyCycles", 0, ramDepth, busyCycles);
        end
    endtask

    // back to back samples, one per cycle
    task automatic drivePair(input sampleT a, input sampleT b);
        sampleValid = 1'b1;
        sampleData = a;
        @(negedge clk);
        sampleData = b;
        @(negedge clk);
    endtask

    task automatic waitIdle();
        int guard;
        guard = 0;
        while (busy && guard < 4 * ramDepth) begin
            @(negedge clk);
            guard++;
        end
        // binReq one cycle, write two more, plus slack
        repeat (4) @(negedge clk);
    endtask

    // each read answered exactly two cycles later
    task automatic readAll();
        for (int a = 0; a < ramDepth; a++) begin
            rdReq = 1'b1;
            rdAddr = ramAddrT'(a);
            @(negedge clk);
            rdReq = 1'b0;
            checkValue("rdValid", a, 0, rdValid);
            @(negedge clk);
            checkValue("rdValid", a, 1, rdValid);
            checkValue("rdData", a, modelCounts[a], rdData);
        end
    endtask

    task automatic runTest(input int t);
        testRowT row;
        int      errorsBefore;
        sampleT  a;
        sampleT  b;
        row = rows[t];
        errorsBefore = failCount;
        writeCfg(regShift, cfgDataT'(row.shift));
        if (row.doClear) begin
            writeCfg(regCtrl, {6'd0, 1'b1, row.enable});
            measureClear();
            modelClear();
        end else begin
            writeCfg(regCtrl, {6'd0, 1'b0, row.enable});
        end
        for (int i = 0; i < row.pairs; i++) begin
            if (row.useRandom) begin
                rngState = xorshift32(rngState);
                a = sampleT'(rngState);
                rngState = xorshift32(rngState);
                b = sampleT'(rngState);
            end else if (row.repeatPair || i % 2 == 0) begin
                a = row.sampA;
                b = row.sampB;
            end else begin
                // swapped order, peak must not depend on it
                a = row.sampB;
                b = row.sampA;
            end
            drivePair(a, b);
            // disabled strobes leave the histogram alone
            if (row.enable) begin
                modelApplyPair(a, b, row.shift);
            end
        end
        sampleValid = 1'b0;
        waitIdle();
        readAll();
        $display("test %0d %s done, %0d errors", t, names[t], failCount - errorsBefore);
    endtask

    initial begin
        rstN = 1'b0;
        cfgWrite = 1'b0;
        cfgAddr = '0;
        cfgData = '0;
        sampleValid = 1'b0;
        sampleData = '0;
        rdReq = 1'b0;
        rdAddr = '0;
        modelClear();

        // clear, enable, shift, pairs, random, repeat, sample a, sample b
        names[0] = "clear";
        rows[0] = '{1'b1, 1'b1, shiftT'(6), 16'd0, 1'b0, 1'b0, sampleT'(0), sampleT'(0)};
        names[1] = "directed 511/1023";
        rows[1] = '{1'b0, 1'b1, shiftT'(6), 16'd8, 1'b0, 1'b0, sampleT'(511), sampleT'(1023)};
        names[2] = "directed 90/200";
        rows[2] = '{1'b0, 1'b1, shiftT'(6), 16'd6, 1'b0, 1'b0, sampleT'(90), sampleT'(200)};
        names[3] = "forwarding";
        rows[3] = '{1'b0, 1'b1, shiftT'(6), 16'd64, 1'b0, 1'b1, sampleT'(300), sampleT'(300)};
        names[4] = "shift 4 random";
        rows[4] = '{1'b0, 1'b1, shiftT'(4), 16'd200, 1'b1, 1'b0, sampleT'(0), sampleT'(0)};
        // 300 hits per pixel on bin 10
        names[5] = "saturation";
        rows[5] = '{1'b1, 1'b1, shiftT'(6), 16'd1200, 1'b0, 1'b1, sampleT'(700), sampleT'(650)};
        names[6] = "disabled";
        rows[6] = '{1'b0, 1'b0, shiftT'(6), 16'd40, 1'b1, 1'b0, sampleT'(0), sampleT'(0)};

        // pairs, clear and drain, three cycles per readout word
        cycleLimit = 200;
        for (int t = 0; t < numTests; t++) begin
            cycleLimit += 2 * rows[t].pairs + 70 + 3 * ramDepth;
        end

        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);

        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end

        $display("checks passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* design/sifhTop.sv */
module sifhTop
    import sifhGeometryPkg::*;
    import sifhCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    cfgWrite,
    input  cfgAddrT cfgAddr,
    input  cfgDataT cfgData,
    input  logic    sampleValid,
    input  sampleT  sampleData,
    input  logic    rdReq,
    input  ramAddrT rdAddr,
    output logic    busy,
    output logic    rdValid,
    output countT   rdData
);

    // config to binner and FSM
    sifhCfgT cfg;
    logic    clearPulse;
    // binner to FSM
    binReqT  binReq;
    // FSM to count RAM
    logic    wEnable;
    ramAddrT waddr;
    countT   newCounts;
    logic    rEnable;
    ramAddrT raddr;
    countT   counts;

    sifhConfig i_config (
        .clk        (clk),
        .rstN       (rstN),
        .cfgWrite   (cfgWrite),
        .cfgAddr    (cfgAddr),
        .cfgData    (cfgData),
        .cfg        (cfg),
        .clearPulse (clearPulse)
    );

    sifhPeakBinner i_binner (
        .clk         (clk),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sampleData  (sampleData),
        .cfg         (cfg),
        .clearPulse  (clearPulse),
        .busy        (busy),
        .binReq      (binReq)
    );

    sifhFsm i_fsm (
        .clk        (clk),
        .rstN       (rstN),
        .cfg        (cfg),
        .clearPulse (clearPulse),
        .binReq     (binReq),
        .counts     (counts),
        .rdReq      (rdReq),
        .rdAddr     (rdAddr),
        .busy       (busy),
        .waddr      (waddr),
        .raddr      (raddr),
        .wEnable    (wEnable),
        .rEnable    (rEnable),
        .newCounts  (newCounts),
        .rdValid    (rdValid),
        .rdData     (rdData)
    );

    sifhCountRam i_ram (
        .clk       (clk),
        .wEnable   (wEnable),
        .waddr     (waddr),
        .newCounts (newCounts),
        .rEnable   (rEnable),
        .raddr     (raddr),
        .counts    (counts)
    );

endmodule

/* design/sifhCountRam.sv */
module sifhCountRam
    import sifhGeometryPkg::*;
(
    input  logic    clk,
    // port A, write
    input  logic    wEnable,
    input  ramAddrT waddr,
    input  countT   newCounts,
    // port B, registered read
    input  logic    rEnable,
    input  ramAddrT raddr,
    output countT   counts
);

    // one word per {pixel, bin}
    countT mem [ramDepth];

    // write lands at the clock edge
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= newCounts;
        end
    end

    // read data one cycle after rEnable
    // same-cycle write to the read address returns the old word
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

endmodule

/* design/sifhFsm.sv */
module sifhFsm
    import sifhGeometryPkg::*;
    import sifhCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  sifhCfgT cfg,
    input  logic    clearPulse,
    input  binReqT  binReq,
    input  countT   counts,
    input  logic    rdReq,
    input  ramAddrT rdAddr,
    output logic    busy,
    output ramAddrT waddr,
    output ramAddrT raddr,
    output logic    wEnable,
    output logic    rEnable,
    output countT   newCounts,
    output logic    rdValid,
    output countT   rdData
);

    fsmStateT state;
    // clear sweep position
    ramAddrT  clrAddr;
    // stage 1 of the increment pipeline
    logic     s1Valid;
    ramAddrT  s1Addr;
    // value written by stage 1 while stage 0 read the same word
    logic     fwdValid;
    countT    fwdCount;
    countT    baseCount;
    countT    incCount;
    // port B users
    logic     accept;
    logic     rdServe;
    logic     rdPend;

    // stage 0 takes a request unless a clear starts or runs
    assign accept = binReq.valid && cfg.enable && !clearPulse && (state != stClear);

    // readout only borrows port B when the pipeline is quiet
    assign rdServe = rdReq && (state != stClear) && !binReq.valid && !s1Valid;

    assign busy = (state == stClear);

    // stale RAM word is replaced by the forwarded result
    assign baseCount = fwdValid ? fwdCount : counts;
    // hold at countMax
    assign incCount = (baseCount == countT'(countMax)) ? baseCount :
                      baseCount + countT'(1);

    // port A, sweep zeros or stage 1 result
    assign wEnable = busy || s1Valid;
    assign waddr = busy ? clrAddr : s1Addr;
    assign newCounts = busy ? '0 : incCount;

    // port B, stage 0 read or readout
    assign rEnable = accept || rdServe;
    assign raddr = accept ? binReq.addr : rdAddr;

    // state and sweep counter
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= stIdle;
            clrAddr <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (clearPulse) begin
                        state <= stClear;
                        clrAddr <= '0;
                    end else if (accept) begin
                        state <= stRun;
                    end
                end
                stRun: begin
                    if (clearPulse) begin
                        state <= stClear;
                        clrAddr <= '0;
                    end else if (!accept && !s1Valid) begin
                        // pipeline drained
                        state <= stIdle;
                    end
                end
                stClear: begin
                    if (clearPulse) begin
                        // new request restarts the sweep
                        clrAddr <= '0;
                    end else if (clrAddr == ramAddrT'(ramDepth - 1)) begin
                        state <= stIdle;
                    end else begin
                        clrAddr <= clrAddr + ramAddrT'(1);
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // pipeline and readout control
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid <= 1'b0;
            fwdValid <= 1'b0;
            rdPend <= 1'b0;
            rdValid <= 1'b0;
        end else begin
            s1Valid <= accept;
            // stage 1 writes the word stage 0 reads, RAM gives the old one
            fwdValid <= accept && s1Valid && (s1Addr == binReq.addr);
            // RAM latency, then output register
            rdPend <= rdServe;
            rdValid <= rdPend;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        s1Addr <= binReq.addr;
        fwdCount <= incCount;
        if (rdPend) begin
            rdData <= counts;
        end
    end

endmodule

/* design/sifhPeakBinner.sv */
module sifhPeakBinner
    import sifhGeometryPkg::*;
    import sifhCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    sampleValid,
    input  sampleT  sampleData,
    input  sifhCfgT cfg,
    input  logic    clearPulse,
    input  logic    busy,
    output binReqT  binReq
);

    // first half of the current pair
    logic                haveFirst;
    sampleT              firstSample;
    // position inside the frame
    logic [pairCntW-1:0] pairCnt;
    pixT                 pixCnt;
    // sample accepted this cycle
    logic                accept;
    logic                pairDone;
    // peak and bin of a completed pair
    sampleT              peak;
    sampleT              shifted;
    binT                 bin;
    // registered request
    logic                reqValid;
    ramAddrT             reqAddr;

    // no samples while disabled, while clearing, or on the clear strobe itself
    assign accept = sampleValid && cfg.enable && !busy && !clearPulse;
    assign pairDone = accept && haveFirst;

    // larger of the two samples
    assign peak = (sampleData > firstSample) ? sampleData : firstSample;
    assign shifted = peak >> cfg.binShift;
    // anything above the last bin lands in it
    assign bin = (shifted > sampleT'(binsPerPixel - 1)) ? binT'(binsPerPixel - 1) :
                 binT'(shifted);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            haveFirst <= 1'b0;
            pairCnt <= '0;
            pixCnt <= '0;
            reqValid <= 1'b0;
        end else begin
            reqValid <= pairDone;
            if (clearPulse) begin
                // restart frame at pixel 0
                haveFirst <= 1'b0;
                pairCnt <= '0;
                pixCnt <= '0;
            end else if (sampleValid && !accept) begin
                // discarded strobe, half-pair is lost
                haveFirst <= 1'b0;
            end else if (accept) begin
                haveFirst <= !haveFirst;
                if (haveFirst) begin
                    // pair complete, step pair and pixel counters
                    if (pairCnt == pairCntW'(dataNum - 1)) begin
                        pairCnt <= '0;
                        pixCnt <= (pixCnt == pixT'(pixelNum - 1)) ? '0 : pixCnt + pixT'(1);
                    end else begin
                        pairCnt <= pairCnt + pairCntW'(1);
                    end
                end
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (accept && !haveFirst) begin
            firstSample <= sampleData;
        end
        if (pairDone) begin
            reqAddr <= {pixCnt, bin};
        end
    end

    assign binReq = '{valid: reqValid, addr: reqAddr};

endmodule

/* design/sifhConfig.sv */
module sifhConfig
    import sifhGeometryPkg::*;
    import sifhCtrlPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  logic    cfgWrite,
    input  cfgAddrT cfgAddr,
    input  cfgDataT cfgData,
    output sifhCfgT cfg,
    output logic    clearPulse
);

    // register writes, visible one cycle after the strobe
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // disabled, default shift
            cfg.enable <= 1'b0;
            cfg.binShift <= shiftT'(defaultShift);
            clearPulse <= 1'b0;
        end else begin
            // clear request lasts a single cycle
            clearPulse <= 1'b0;
            if (cfgWrite) begin
                case (cfgAddr)
                    regCtrl: begin
                        cfg.enable <= cfgData[ctrlEnableBit];
                        // bit1 only triggers, it is never stored
                        clearPulse <= cfgData[ctrlClearBit];
                    end
                    regShift: begin
                        // upper data bits have no meaning
                        cfg.binShift <= cfgData[shiftW-1:0];
                    end
                    regStatus: begin
                        // busy comes from the FSM, nothing to write
                    end
                    default: begin
                        // unused address
                    end
                endcase
            end
        end
    end

endmodule

/* design/sifhCtrlPkg.sv */
package sifhCtrlPkg;

    import sifhGeometryPkg::*;

    // FSM states
    typedef enum logic [1:0] {
        stIdle,
        stClear,
        stRun
    } fsmStateT;

    // config register index and write data
    typedef logic [1:0] cfgAddrT;
    localparam int cfgDataW = 8;
    typedef logic [cfgDataW-1:0] cfgDataT;

    // register map
    localparam cfgAddrT regCtrl = 2'd0;
    localparam cfgAddrT regShift = 2'd1;
    // read-only busy flag, writes are ignored
    localparam cfgAddrT regStatus = 2'd2;

    // bits of regCtrl
    localparam int ctrlEnableBit = 0;
    localparam int ctrlClearBit = 1;

    // settings seen by binner and FSM
    typedef struct packed {
        logic enable;
        shiftT binShift;
    } sifhCfgT;

    // one bin increment for the FSM
    typedef struct packed {
        logic valid;
        ramAddrT addr;
    } binReqT;

endpackage

/* design/sifhGeometryPkg.sv */
package sifhGeometryPkg;

    // one sensor sample
    localparam int sampleW = 10;

    // bins per pixel histogram
    localparam int binW = 4;
    localparam int binsPerPixel = 1 << binW;

    // pixels sharing one count RAM
    localparam int pixelNum = 4;
    localparam int pixW = 2;

    // sample pairs delivered per pixel
    localparam int dataNum = 2;
    localparam int pairCntW = (dataNum > 1) ? $clog2(dataNum) : 1;

    // count RAM, address is {pixel, bin}
    localparam int ramAddrW = 6;
    localparam int ramDepth = pixelNum * binsPerPixel;

    // bin counts saturate here
    localparam int countW = 8;
    localparam int countMax = 255;

    // right shift from peak sample to bin
    localparam int shiftW = 4;
    // shift after reset, top 4 of 10 sample bits
    localparam int defaultShift = 6;

    typedef logic [sampleW-1:0] sampleT;
    typedef logic [binW-1:0] binT;
    typedef logic [pixW-1:0] pixT;
    typedef logic [ramAddrW-1:0] ramAddrT;
    typedef logic [countW-1:0] countT;
    typedef logic [shiftW-1:0] shiftT;

endpackage
